// ==== md5_core.f ====
+incdir+tests
rtl/md5_const_pkg.sv
rtl/md5_ctrl_pkg.sv
rtl/md5_round_rom.sv
rtl/md5_msg_buffer.sv
rtl/md5_round_logic.sv
rtl/md5_chunk_cruncher.sv
rtl/md5_core.sv
tests/md5_core_tb.sv

// ==== rtl/md5_chunk_cruncher.sv ====
module md5_chunk_cruncher
    import md5_const_pkg::*, md5_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    output logic        done,
    output logic [127:0] digest,
    output logic [5:0]  round_idx,
    output round_fn_t   round_fn,
    input  logic [31:0] k_word,
    input  logic [31:0] m_word,
    input  logic [31:0] f_word,
    output logic [31:0] b_work,
    output logic [31:0] c_work,
    output logic [31:0] d_work,
    output logic [31:0] rot_in,
    input  logic [31:0] rot_out
);

    // chaining digest
    logic [31:0] a0;
    logic [31:0] b0;
    logic [31:0] c0;
    logic [31:0] d0;

    // working registers for the current chunk
    logic [31:0] areg;
    logic [31:0] breg;
    logic [31:0] creg;
    logic [31:0] dreg;

    logic [31:0] freg;
    logic [31:0] t0;
    logic [31:0] t1;

    logic [5:0]  ireg;
    stage_t      stage;
    step_t       step;

    logic [31:0] add_a;
    logic [31:0] add_b;
    logic [31:0] add_sum;

    assign digest    = {d0, c0, b0, a0};
    assign done      = (stage == stage_finished);
    assign round_idx = ireg;
    assign round_fn  = round_fn_t'(ireg[5:4]);
    assign b_work    = breg;
    assign c_work    = creg;
    assign d_work    = dreg;
    assign rot_in    = t0;

    // single adder, operands chosen by stage and step
    always_comb begin
        add_a = '0;
        add_b = '0;
        if (stage == stage_crunch) begin
            case (step)
                step_0: begin
                    add_a = areg;
                    add_b = k_word;
                end
                step_1: begin
                    add_a = freg;
                    add_b = m_word;
                end
                step_2: begin
                    add_a = t0;
                    add_b = t1;
                end
                default: begin
                    add_a = breg;
                    add_b = rot_out;
                end
            endcase
        end else if (stage == stage_finalize) begin
            case (step)
                step_0: begin
                    add_a = a0;
                    add_b = areg;
                end
                step_1: begin
                    add_a = b0;
                    add_b = breg;
                end
                step_2: begin
                    add_a = c0;
                    add_b = creg;
                end
                default: begin
                    add_a = d0;
                    add_b = dreg;
                end
            endcase
        end
    end

    assign add_sum = add_a + add_b;

    // control state and chaining words
    always_ff @(posedge clk) begin
        if (reset) begin
            a0    <= init_a;
            b0    <= init_b;
            c0    <= init_c;
            d0    <= init_d;
            ireg  <= '0;
            step  <= step_0;
            stage <= stage_finished;
        end else if (start) begin
            ireg  <= '0;
            step  <= step_0;
            stage <= stage_crunch;
        end else if (stage == stage_crunch) begin
            step <= step_t'(step + 2'd1);
            if (step == step_3) begin
                // index wraps to 0 after the last round
                ireg <= ireg + 6'd1;
                if (ireg == 6'd63) begin
                    stage <= stage_finalize;
                end
            end
        end else if (stage == stage_finalize) begin
            step <= step_t'(step + 2'd1);
            case (step)
                step_0: a0 <= add_sum;
                step_1: b0 <= add_sum;
                step_2: c0 <= add_sum;
                default: begin
                    d0    <= add_sum;
                    stage <= stage_finished;
                end
            endcase
        end
    end

    // round datapath
    always_ff @(posedge clk) begin
        if (start) begin
            areg <= a0;
            breg <= b0;
            creg <= c0;
            dreg <= d0;
        end else if (stage == stage_crunch) begin
            case (step)
                step_0: begin
                    freg <= f_word;
                    t0   <= add_sum;
                end
                step_1: t1 <= add_sum;
                step_2: t0 <= add_sum;
                default: begin
                    areg <= dreg;
                    breg <= add_sum;
                    creg <= breg;
                    dreg <= creg;
                end
            endcase
        end
    end

endmodule

// ==== rtl/md5_const_pkg.sv ====
package md5_const_pkg;

    // initial chaining words
    localparam logic [31:0] init_a = 32'h67452301;
    localparam logic [31:0] init_b = 32'hefcdab89;
    localparam logic [31:0] init_c = 32'h98badcfe;
    localparam logic [31:0] init_d = 32'h10325476;

    // sine-derived additive constants, one per round
    localparam logic [31:0] k_table [0:63] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // rotate amounts, repeating every four rounds within a group
    localparam logic [4:0] s_table [0:15] = '{
        5'd7,  5'd12, 5'd17, 5'd22,
        5'd5,  5'd9,  5'd14, 5'd20,
        5'd4,  5'd11, 5'd16, 5'd23,
        5'd6,  5'd10, 5'd15, 5'd21
    };

endpackage

// ==== rtl/md5_core.sv ====
module md5_core
    import md5_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    output logic         done,
    output logic [127:0] digest,
    input  logic         msg_we,
    input  logic [3:0]   msg_addr,
    input  logic [31:0]  msg_data
);

    logic [5:0]  round_idx;
    round_fn_t   round_fn;
    logic [31:0] k_word;
    logic [4:0]  shift;
    logic [31:0] m_word;
    logic [31:0] f_word;
    logic [31:0] b_work;
    logic [31:0] c_work;
    logic [31:0] d_work;
    logic [31:0] rot_in;
    logic [31:0] rot_out;

    md5_chunk_cruncher u_cruncher (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .done      (done),
        .digest    (digest),
        .round_idx (round_idx),
        .round_fn  (round_fn),
        .k_word    (k_word),
        .m_word    (m_word),
        .f_word    (f_word),
        .b_work    (b_work),
        .c_work    (c_work),
        .d_work    (d_work),
        .rot_in    (rot_in),
        .rot_out   (rot_out)
    );

    md5_round_rom u_rom (
        .round_idx (round_idx),
        .k_word    (k_word),
        .shift     (shift)
    );

    md5_msg_buffer u_msg (
        .clk       (clk),
        .reset     (reset),
        .msg_we    (msg_we),
        .msg_addr  (msg_addr),
        .msg_data  (msg_data),
        .round_idx (round_idx),
        .m_word    (m_word)
    );

    md5_round_logic u_logic (
        .round_fn (round_fn),
        .b        (b_work),
        .c        (c_work),
        .d        (d_work),
        .f_word   (f_word),
        .rot_in   (rot_in),
        .shift    (shift),
        .rot_out  (rot_out)
    );

endmodule

// ==== rtl/md5_ctrl_pkg.sv ====
package md5_ctrl_pkg;

    typedef enum logic [1:0] {
        stage_crunch   = 2'd0,
        stage_finalize = 2'd1,
        stage_finished = 2'd2
    } stage_t;

    // sub-cycle within a round or within finalize
    typedef enum logic [1:0] {
        step_0 = 2'd0,
        step_1 = 2'd1,
        step_2 = 2'd2,
        step_3 = 2'd3
    } step_t;

    // selected by round_idx[5:4]
    typedef enum logic [1:0] {
        fn_f = 2'd0,
        fn_g = 2'd1,
        fn_h = 2'd2,
        fn_i = 2'd3
    } round_fn_t;

endpackage

// ==== rtl/md5_msg_buffer.sv ====
module md5_msg_buffer (
    input  logic        clk,
    input  logic        reset,
    input  logic        msg_we,
    input  logic [3:0]  msg_addr,
    input  logic [31:0] msg_data,
    input  logic [5:0]  round_idx,
    output logic [31:0] m_word
);

    logic [31:0] mem [0:15];
    logic [3:0]  i_lo;
    logic [3:0]  g;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < 16; n++) begin
                mem[n] <= '0;
            end
        end else if (msg_we) begin
            mem[msg_addr] <= msg_data;
        end
    end

    // all g formulas are modulo 16, so only the low index bits matter
    assign i_lo = round_idx[3:0];

    always_comb begin
        case (round_idx[5:4])
            2'd0: g = i_lo;
            2'd1: g = 4'd5 * i_lo + 4'd1;
            2'd2: g = 4'd3 * i_lo + 4'd5;
            default: g = 4'd7 * i_lo;
        endcase
    end

    assign m_word = mem[g];

endmodule

// ==== rtl/md5_round_logic.sv ====
module md5_round_logic
    import md5_ctrl_pkg::*;
(
    input  round_fn_t   round_fn,
    input  logic [31:0] b,
    input  logic [31:0] c,
    input  logic [31:0] d,
    output logic [31:0] f_word,
    input  logic [31:0] rot_in,
    input  logic [4:0]  shift,
    output logic [31:0] rot_out
);

    logic [63:0] rot_wide;

    always_comb begin
        case (round_fn)
            fn_f: f_word = (b & c) | (~b & d);
            fn_g: f_word = (d & b) | (~d & c);
            fn_h: f_word = b ^ c ^ d;
            default: f_word = c ^ (b | ~d);
        endcase
    end

    // bits shifted out of the top reappear at the bottom
    assign rot_wide = {rot_in, rot_in} << shift;
    assign rot_out  = rot_wide[63:32];

endmodule

// ==== rtl/md5_round_rom.sv ====
module md5_round_rom
    import md5_const_pkg::*;
(
    input  logic [5:0]  round_idx,
    output logic [31:0] k_word,
    output logic [4:0]  shift
);

    logic [3:0] s_sel;

    // group in the upper bits, position within the group of four below
    assign s_sel  = {round_idx[5:4], round_idx[1:0]};

    assign k_word = k_table[round_idx];
    assign shift  = s_table[s_sel];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the MD5 core testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module md5_core_tb \
    -f md5_core.f \
    -o md5_core_sim

./obj_dir/md5_core_sim

// ==== tests/md5_ref_model.svh ====
`ifndef md5_ref_model_svh
`define md5_ref_model_svh

// 32-bit left rotate
function automatic logic [31:0] rotate_left(input logic [31:0] x, input int s);
    return (x << s) | (x >> (32 - s));
endfunction

// F, G, H and I from RFC 1321, picked by round group
function automatic logic [31:0] boolean_mix(
    input int          grp,
    input logic [31:0] b,
    input logic [31:0] c,
    input logic [31:0] d
);
    logic [31:0] r;
    case (grp)
        0: r = (b & c) | (~b & d);
        1: r = (b & d) | (c & ~d);
        2: r = b ^ c ^ d;
        default: r = c ^ (b | ~d);
    endcase
    return r;
endfunction

// message word used by round i
function automatic logic [3:0] schedule_index(input int i);
    int g;
    case (i / 16)
        0: g = i;
        1: g = 5 * i + 1;
        2: g = 3 * i + 5;
        default: g = 7 * i;
    endcase
    return 4'(g % 16);
endfunction

// one chunk compression, state and result ordered {d, c, b, a}
function automatic logic [127:0] compress_chunk(
    input logic [127:0] state,
    input logic [31:0]  w [0:15]
);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] f;
    int          s;
    a = state[31:0];
    b = state[63:32];
    c = state[95:64];
    d = state[127:96];
    for (int i = 0; i < 64; i++) begin
        s = int'(s_table[4'((i / 16) * 4 + i % 4)]);
        f = boolean_mix(i / 16, b, c, d) + a + k_table[6'(i)] + w[schedule_index(i)];
        a = d;
        d = c;
        c = b;
        b = b + rotate_left(f, s);
    end
    return {d + state[127:96], c + state[95:64], b + state[63:32], a + state[31:0]};
endfunction

`endif

// ==== tests/md5_core_tb.sv ====
module md5_core_tb
    import md5_const_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int           latency_cycles = 260;
    localparam int           done_timeout   = 1000;
    localparam logic [127:0] init_digest    = {init_d, init_c, init_b, init_a};
    // published MD5 of the empty string as little-endian words
    localparam logic [127:0] empty_digest   = 128'h7e42f8ec_980980e9_04b2008f_d98c1dd4;

    logic         clk;
    logic         reset;
    logic         start;
    logic         done;
    logic [127:0] digest;
    logic         msg_we;
    logic [3:0]   msg_addr;
    logic [31:0]  msg_data;

    logic [31:0]  chunk_a [0:15];
    logic [31:0]  chunk_b [0:15];
    logic [127:0] expected;

    `include "md5_ref_model.svh"

    md5_core u_md5_core (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .done     (done),
        .digest   (digest),
        .msg_we   (msg_we),
        .msg_addr (msg_addr),
        .msg_data (msg_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic expect_equal(
        input string        name,
        input logic [127:0] exp_value,
        input logic [127:0] act_value
    );
        assert (act_value === exp_value) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp_value, act_value);
            $display("Verification failed");
            $fatal(1, "%s returned a wrong value", name);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic fill_random_words(output logic [31:0] w [0:15]);
        for (int n = 0; n < 16; n++) begin
            w[n] = $urandom;
        end
    endtask

    task automatic load_chunk(input logic [31:0] w [0:15]);
        for (int n = 0; n < 16; n++) begin
            @(negedge clk);
            msg_we   = 1'b1;
            msg_addr = 4'(n);
            msg_data = w[n];
        end
        @(negedge clk);
        msg_we = 1'b0;
    endtask

    // pulse start, then count edges until done with a timeout
    task automatic run_chunk(input string name);
        int waited;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        expect_equal({name, " done low after start"}, 128'(1'b0), 128'(done));
        waited = 0;
        while (!done && waited < done_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("Verification failed");
            $fatal(1, "timeout: done never rose for %s", name);
        end
        expect_equal({name, " latency"}, 128'(latency_cycles), 128'(waited));
    endtask

    initial begin
        reset    = 1'b0;
        start    = 1'b0;
        msg_we   = 1'b0;
        msg_addr = 4'd0;
        msg_data = 32'd0;
        void'($urandom(32'h864e80a2));

        apply_reset();
        expect_equal("reset done", 128'(1'b1), 128'(done));
        expect_equal("reset digest", init_digest, digest);

        // padded empty message is one 0x80 byte then zeros and a zero bit length
        for (int n = 0; n < 16; n++) begin
            chunk_a[n] = 32'd0;
        end
        chunk_a[0] = 32'h00000080;
        expected = compress_chunk(init_digest, chunk_a);
        expect_equal("empty model", empty_digest, expected);
        load_chunk(chunk_a);
        run_chunk("empty vector");
        expect_equal("empty vector", expected, digest);

        for (int t = 0; t < 4; t++) begin
            apply_reset();
            fill_random_words(chunk_a);
            expected = compress_chunk(init_digest, chunk_a);
            load_chunk(chunk_a);
            run_chunk($sformatf("random chunk %0d", t));
            expect_equal($sformatf("random chunk %0d", t), expected, digest);
        end

        // two chunks of one message without reset in between
        apply_reset();
        fill_random_words(chunk_a);
        fill_random_words(chunk_b);
        expected = compress_chunk(init_digest, chunk_a);
        load_chunk(chunk_a);
        run_chunk("chain first");
        expect_equal("chain first", expected, digest);
        expected = compress_chunk(expected, chunk_b);
        load_chunk(chunk_b);
        run_chunk("chain second");
        expect_equal("chain second", expected, digest);

        // reset while rounds are still running
        load_chunk(chunk_a);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (100) @(negedge clk);
        expect_equal("mid-run busy", 128'(1'b0), 128'(done));
        apply_reset();
        expect_equal("mid-run reset done", 128'(1'b1), 128'(done));
        expect_equal("mid-run reset digest", init_digest, digest);

        expected = compress_chunk(init_digest, chunk_b);
        load_chunk(chunk_b);
        run_chunk("after mid-run reset");
        expect_equal("after mid-run reset", expected, digest);

        $display("Verification passed");
        $finish;
    end

endmodule
